/* cr_io.f */
source/cr_map_pkg.sv
source/board_io_pkg.sv
source/kbd_fifo.sv
source/cr_mem.sv
source/cr_io_top.sv
verif/cr_io_tb.sv

/* source/board_io_pkg.sv */
// Board I/O package: pin bundles and the keyboard queue control and read words
package board_io_pkg;

    // ----------------------------------------
    // Board pins
    // ----------------------------------------

    // Raw board inputs, 36 bits
    typedef struct packed {
        logic                              button_0;
        logic                              button_1;
        logic [cr_map_pkg::SWITCH_W-1:0]   switch;
        logic [cr_map_pkg::JOY_W-1:0]      joystick_x;
        logic [cr_map_pkg::JOY_W-1:0]      joystick_y;
    } t_fpga_in;

    // Board outputs, 58 bits
    // Segment bytes go to external decoders
    typedef struct packed {
        logic [cr_map_pkg::SEG7_W-1:0]     seg7_0;
        logic [cr_map_pkg::SEG7_W-1:0]     seg7_1;
        logic [cr_map_pkg::SEG7_W-1:0]     seg7_2;
        logic [cr_map_pkg::SEG7_W-1:0]     seg7_3;
        logic [cr_map_pkg::SEG7_W-1:0]     seg7_4;
        logic [cr_map_pkg::SEG7_W-1:0]     seg7_5;
        logic [cr_map_pkg::LED_W-1:0]      led;
    } t_fpga_out;

    // ----------------------------------------
    // Keyboard queue
    // ----------------------------------------

    // Head of queue as seen by the register block
    typedef struct packed {
        logic                              kbd_ready;
        logic [cr_map_pkg::KBD_W-1:0]      kbd_data;
    } t_kbd_data_rd;

    // Register block to queue
    typedef struct packed {
        logic                              kbd_pop;
        logic                              kbd_scanf_en;
    } t_kbd_ctrl;

endpackage

/* source/cr_io_top.sv */
// Control-register I/O top: register memory joined to the keyboard scan-code queue
`timescale 1ns/1ps

module cr_io_top #(
    parameter int KBD_FIFO_DEPTH = 8
) (
    input  logic                             Clk,
    input  logic                             reset,
    // Core port
    input  logic [cr_map_pkg::CR_DATA_W-1:0] data,
    input  logic [31:0]                      address,
    input  logic                             wren,
    input  logic                             rden,
    output logic [cr_map_pkg::CR_DATA_W-1:0] q,
    // Fabric port
    input  logic [31:0]                      address_b,
    output logic [cr_map_pkg::CR_DATA_W-1:0] q_b,
    // Board pins
    input  board_io_pkg::t_fpga_in           fpga_in,
    output board_io_pkg::t_fpga_out          fpga_out,
    // Scan codes from the PS/2 receiver
    input  logic                             scan_valid,
    input  logic [cr_map_pkg::KBD_W-1:0]     scan_code
);
    import board_io_pkg::*;

    // Register block <-> queue
    t_kbd_ctrl    kbd_ctrl;
    t_kbd_data_rd kbd_data_rd;

    // Register memory
    cr_mem u_cr_mem (
        .Clk         (Clk),
        .reset       (reset),
        .data        (data),
        .address     (address),
        .wren        (wren),
        .rden        (rden),
        .q           (q),
        .address_b   (address_b),
        .q_b         (q_b),
        .fpga_in     (fpga_in),
        .kbd_data_rd (kbd_data_rd),
        .kbd_ctrl    (kbd_ctrl),
        .fpga_out    (fpga_out)
    );

    // Keyboard scan-code queue
    kbd_fifo #(
        .KBD_FIFO_DEPTH (KBD_FIFO_DEPTH)
    ) u_kbd_fifo (
        .Clk         (Clk),
        .reset       (reset),
        .scan_valid  (scan_valid),
        .scan_code   (scan_code),
        .kbd_ctrl    (kbd_ctrl),
        .kbd_data_rd (kbd_data_rd)
    );

endmodule

/* source/cr_map_pkg.sv */
// Control-register map package: register offsets, word width and board field widths
package cr_map_pkg;

    // ----------------------------------------
    // Word and field widths
    // ----------------------------------------

    // Register word on both ports
    localparam int CR_DATA_W = 32;

    // One seven-segment digit byte
    localparam int SEG7_W    = 8;
    // LED bank
    localparam int LED_W     = 10;
    // Slide switches
    localparam int SWITCH_W  = 10;
    // Joystick axis sample, per axis
    localparam int JOY_W     = 12;
    // PS/2 scan-code byte
    localparam int KBD_W     = 8;

    // ----------------------------------------
    // Register offsets
    // ----------------------------------------

    // Word aligned, step of 4, anything else unmapped
    typedef enum logic [31:0] {
        // Read/write from the core, read only from the fabric
        CR_SEG7_0       = 32'h0000_0000,
        CR_SEG7_1       = 32'h0000_0004,
        CR_SEG7_2       = 32'h0000_0008,
        CR_SEG7_3       = 32'h0000_000C,
        CR_SEG7_4       = 32'h0000_0010,
        CR_SEG7_5       = 32'h0000_0014,
        CR_LED          = 32'h0000_0018,
        CR_KBD_SCANF_EN = 32'h0000_001C,
        // Read only, sampled from the board or the keyboard queue
        CR_BUTTON_0     = 32'h0000_0020,
        CR_BUTTON_1     = 32'h0000_0024,
        CR_SWITCH       = 32'h0000_0028,
        CR_JOYSTICK_X   = 32'h0000_002C,
        CR_JOYSTICK_Y   = 32'h0000_0030,
        CR_KBD_READY    = 32'h0000_0034,
        CR_KBD_DATA     = 32'h0000_0038
    } t_cr_addr;

endpackage

/* source/cr_mem.sv */
// Control-register memory: core and fabric read ports, board input sync, output pipeline
`timescale 1ns/1ps

module cr_mem (
    input  logic                             Clk,
    input  logic                             reset,
    // Core port
    input  logic [cr_map_pkg::CR_DATA_W-1:0] data,
    input  logic [31:0]                      address,
    input  logic                             wren,
    input  logic                             rden,
    output logic [cr_map_pkg::CR_DATA_W-1:0] q,
    // Fabric port, read only
    input  logic [31:0]                      address_b,
    output logic [cr_map_pkg::CR_DATA_W-1:0] q_b,
    // Board inputs, asynchronous
    input  board_io_pkg::t_fpga_in           fpga_in,
    // Keyboard queue
    input  board_io_pkg::t_kbd_data_rd       kbd_data_rd,
    output board_io_pkg::t_kbd_ctrl          kbd_ctrl,
    // Board outputs
    output board_io_pkg::t_fpga_out          fpga_out
);
    import cr_map_pkg::*;
    import board_io_pkg::*;

    // Input sync chain: fpga_in -> fpga_in_1 -> fpga_in_2
    t_fpga_in             fpga_in_1;
    t_fpga_in             fpga_in_2;

    // Output pipeline: out_pend_next -> out_pend -> fpga_out
    t_fpga_out            out_pend;
    t_fpga_out            out_pend_next;

    // Keyboard register, head of queue one edge late
    t_kbd_data_rd         kbd_reg;
    logic                 scanf_en;
    logic                 scanf_en_next;

    // Read words before the output flops
    logic [CR_DATA_W-1:0] pre_q;
    logic [CR_DATA_W-1:0] pre_q_b;

    // Read mux shared by both ports
    // Fields zero-extended to the word, unmapped offsets read zero
    function automatic logic [CR_DATA_W-1:0] read_word(input logic [31:0] addr);
        logic [CR_DATA_W-1:0] word;
        word = '0;
        case (t_cr_addr'(addr))
            // Read/write registers, from the live output stage
            CR_SEG7_0:       word = CR_DATA_W'(fpga_out.seg7_0);
            CR_SEG7_1:       word = CR_DATA_W'(fpga_out.seg7_1);
            CR_SEG7_2:       word = CR_DATA_W'(fpga_out.seg7_2);
            CR_SEG7_3:       word = CR_DATA_W'(fpga_out.seg7_3);
            CR_SEG7_4:       word = CR_DATA_W'(fpga_out.seg7_4);
            CR_SEG7_5:       word = CR_DATA_W'(fpga_out.seg7_5);
            CR_LED:          word = CR_DATA_W'(fpga_out.led);
            CR_KBD_SCANF_EN: word = CR_DATA_W'(scanf_en);
            // Read-only registers
            CR_BUTTON_0:     word = CR_DATA_W'(fpga_in_2.button_0);
            CR_BUTTON_1:     word = CR_DATA_W'(fpga_in_2.button_1);
            CR_SWITCH:       word = CR_DATA_W'(fpga_in_2.switch);
            CR_JOYSTICK_X:   word = CR_DATA_W'(fpga_in_2.joystick_x);
            CR_JOYSTICK_Y:   word = CR_DATA_W'(fpga_in_2.joystick_y);
            CR_KBD_READY:    word = CR_DATA_W'(kbd_reg.kbd_ready);
            CR_KBD_DATA:     word = CR_DATA_W'(kbd_reg.kbd_data);
            default:         word = '0;
        endcase
        return word;
    endfunction

    // ----------------------------------------
    // Core write decode
    // ----------------------------------------

    // Pending word holds its value unless written
    always_comb begin
        out_pend_next = out_pend;
        scanf_en_next = scanf_en;
        if (wren) begin
            case (t_cr_addr'(address))
                CR_SEG7_0:       out_pend_next.seg7_0 = data[SEG7_W-1:0];
                CR_SEG7_1:       out_pend_next.seg7_1 = data[SEG7_W-1:0];
                CR_SEG7_2:       out_pend_next.seg7_2 = data[SEG7_W-1:0];
                CR_SEG7_3:       out_pend_next.seg7_3 = data[SEG7_W-1:0];
                CR_SEG7_4:       out_pend_next.seg7_4 = data[SEG7_W-1:0];
                CR_SEG7_5:       out_pend_next.seg7_5 = data[SEG7_W-1:0];
                CR_LED:          out_pend_next.led    = data[LED_W-1:0];
                CR_KBD_SCANF_EN: scanf_en_next        = data[0];
                // Read-only and unmapped offsets ignore writes
                default: begin
                    out_pend_next = out_pend;
                end
            endcase
        end
    end

    // ----------------------------------------
    // Read paths
    // ----------------------------------------

    always_comb begin
        // Core read zero without rden
        pre_q   = rden ? read_word(address) : '0;
        // Fabric reads every cycle
        pre_q_b = read_word(address_b);
    end

    // ----------------------------------------
    // Registers
    // ----------------------------------------

    always_ff @(posedge Clk) begin
        if (reset) begin
            out_pend <= '0;
            fpga_out <= '0;
            scanf_en <= 1'b0;
            kbd_reg  <= '0;
            q        <= '0;
            q_b      <= '0;
        end else begin
            // Write lands in pending stage, pins one edge later
            out_pend <= out_pend_next;
            fpga_out <= out_pend;
            scanf_en <= scanf_en_next;
            kbd_reg  <= kbd_data_rd;
            q        <= pre_q;
            q_b      <= pre_q_b;
        end
    end

    // Two-flop sync of board pins
    always_ff @(posedge Clk) begin
        fpga_in_1 <= fpga_in;
        fpga_in_2 <= fpga_in_1;
    end

    // ----------------------------------------
    // Keyboard queue control
    // ----------------------------------------

    // Pop at the edge of a core read of the data register
    always_comb begin
        kbd_ctrl.kbd_pop      = rden && (address == CR_KBD_DATA);
        kbd_ctrl.kbd_scanf_en = scanf_en;
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // Core port is single-access per cycle
    a_no_rd_wr : assert property (
        @(posedge Clk) disable iff (reset)
        !(wren && rden)
    ) else $error("cr_mem: wren and rden high together");

    // No queue pop may slip in during reset
    a_no_pop_in_reset : assert property (
        @(posedge Clk)
        reset |-> !kbd_ctrl.kbd_pop
    ) else $error("cr_mem: kbd_pop during reset");

endmodule

/* source/kbd_fifo.sv */
// Keyboard scan-code FIFO: pushes strobed codes while scanning is enabled, pops on core read
`timescale 1ns/1ps

module kbd_fifo #(
    parameter int KBD_FIFO_DEPTH = 8
) (
    input  logic                         Clk,
    input  logic                         reset,
    // Ready-made scan code from the PS/2 receiver
    input  logic                         scan_valid,
    input  logic [cr_map_pkg::KBD_W-1:0] scan_code,
    // Pop and scan enable from the register block
    input  board_io_pkg::t_kbd_ctrl      kbd_ctrl,
    // Head of queue back to the register block
    output board_io_pkg::t_kbd_data_rd   kbd_data_rd
);
    import cr_map_pkg::*;

    // Depth is a power of two, so pointers wrap on their own
    localparam int PTR_W = $clog2(KBD_FIFO_DEPTH);
    // One extra state for the full queue
    localparam int CNT_W = $clog2(KBD_FIFO_DEPTH + 1);

    // Code storage
    logic [KBD_W-1:0] mem [KBD_FIFO_DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    logic             empty;
    logic             full;
    logic             push;
    logic             pop;

    // ----------------------------------------
    // Status and qualified strobes
    // ----------------------------------------

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(KBD_FIFO_DEPTH));

    // Codes seen while scanning is off, or while full, are lost
    assign push  = scan_valid && kbd_ctrl.kbd_scanf_en && !full;
    // Pop of an empty queue is ignored
    assign pop   = kbd_ctrl.kbd_pop && !empty;

    // ----------------------------------------
    // Storage and pointers
    // ----------------------------------------

    // Write side of the buffer
    always_ff @(posedge Clk) begin
        if (push) begin
            mem[wr_ptr] <= scan_code;
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Push and pop together leave the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head of queue, same cycle
    // Data forced to zero while empty so a stray read sees no stale code
    always_comb begin
        kbd_data_rd.kbd_ready = !empty;
        kbd_data_rd.kbd_data  = empty ? '0 : mem[rd_ptr];
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // Occupancy bound over any push/pop sequence
    a_count_bound : assert property (
        @(posedge Clk) disable iff (reset)
        count <= CNT_W'(KBD_FIFO_DEPTH)
    ) else $error("kbd_fifo: count %0d above depth %0d", count, KBD_FIFO_DEPTH);

endmodule

/* verif/cr_io_tb.sv */
// Control-register I/O testbench: replays a trace of core, fabric, pin and scan-code operations
`timescale 1ns/1ps

module cr_io_tb;
    import cr_map_pkg::*;
    import board_io_pkg::*;

    // Bounds on trace length and on one idle stretch
    localparam int MAX_STEPS = 2000;
    localparam int MAX_IDLE  = 64;

    logic                 Clk;
    logic                 reset;
    logic [CR_DATA_W-1:0] data;
    logic [31:0]          address;
    logic                 wren;
    logic                 rden;
    logic [CR_DATA_W-1:0] q;
    logic [31:0]          address_b;
    logic [CR_DATA_W-1:0] q_b;
    t_fpga_in             fpga_in;
    t_fpga_out            fpga_out;
    logic                 scan_valid;
    logic [KBD_W-1:0]     scan_code;

    // One trace entry: op letter, address, data, expected value
    logic [31:0]          t_addr;
    logic [63:0]          t_data;
    logic [63:0]          t_exp;
    logic [8*160-1:0]     skip_buf;

    int fd;
    int ch;
    int n_read;
    int steps;
    int i;
    int checks;
    int errors;
    int test_checks0;
    int test_errors0;
    bit done;
    bit aborted;

    cr_io_top #(
        .KBD_FIFO_DEPTH (4)
    ) u_dut (
        .Clk        (Clk),
        .reset      (reset),
        .data       (data),
        .address    (address),
        .wren       (wren),
        .rden       (rden),
        .q          (q),
        .address_b  (address_b),
        .q_b        (q_b),
        .fpga_in    (fpga_in),
        .fpga_out   (fpga_out),
        .scan_valid (scan_valid),
        .scan_code  (scan_code)
    );

    // 100 ns clock
    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    // Rising edge, then the 5 ns drive offset
    task automatic next_edge();
        @(posedge Clk);
        #5;
    endtask

    task automatic idle_cycles(input logic [63:0] n);
        int k;
        if (n > MAX_IDLE) begin
            $display("Idle stretch of %0d cycles exceeds the %0d-cycle limit", n, MAX_IDLE);
            aborted = 1'b1;
        end else begin
            for (k = 0; k < n; k++) begin
                next_edge();
            end
        end
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] got);
        errors++;
        $display("CHECK FAILED at %0t ns: %s, addr 0x%08h got 0x%0h, expected 0x%0h",
                 $time, what, t_addr, got, t_exp);
    endtask

    // ----------------------------------------
    // Trace operations
    // ----------------------------------------

    task automatic run_op(input logic [7:0] op);
        case (op)
            "W": begin
                address = t_addr;
                data    = t_data[CR_DATA_W-1:0];
                wren    = 1'b1;
                next_edge();
                wren    = 1'b0;
            end
            // Result registered at the sampling edge
            "R": begin
                address = t_addr;
                rden    = 1'b1;
                next_edge();
                rden    = 1'b0;
                checks++;
                if (64'(q) !== t_exp) begin
                    report_mismatch("core read", 64'(q));
                end
            end
            "B": begin
                address_b = t_addr;
                next_edge();
                checks++;
                if (64'(q_b) !== t_exp) begin
                    report_mismatch("fabric read", 64'(q_b));
                end
            end
            "I": begin
                fpga_in = t_fpga_in'(t_data[$bits(t_fpga_in)-1:0]);
                next_edge();
            end
            "K": begin
                scan_code  = t_data[KBD_W-1:0];
                scan_valid = 1'b1;
                next_edge();
                scan_valid = 1'b0;
                // Second edge lets the queue head reach the keyboard register
                next_edge();
            end
            // Pins sampled mid-cycle, no edge used
            "E": begin
                checks++;
                if (64'(fpga_out) !== t_exp) begin
                    report_mismatch("fpga_out pins", 64'(fpga_out));
                end
            end
            "N": idle_cycles(t_data);
            "T": begin
                $display("test %0d done: %0d checks, %0d errors", t_data,
                         checks - test_checks0, errors - test_errors0);
                test_checks0 = checks;
                test_errors0 = errors;
            end
            default: begin
                $display("Unknown trace op '%c', run stopped", op);
                aborted = 1'b1;
            end
        endcase
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        reset      = 1'b1;
        data       = '0;
        address    = '0;
        wren       = 1'b0;
        rden       = 1'b0;
        address_b  = '0;
        fpga_in    = '0;
        scan_valid = 1'b0;
        scan_code  = '0;
        checks     = 0;
        errors     = 0;
        steps      = 0;
        done       = 1'b0;
        aborted    = 1'b0;
        test_checks0 = 0;
        test_errors0 = 0;

        // Five edges in reset
        for (i = 0; i < 5; i++) begin
            @(posedge Clk);
        end
        #5;
        reset = 1'b0;

        fd = $fopen("verif/cr_io_trace.txt", "r");
        if (fd == 0) begin
            $display("Trace file verif/cr_io_trace.txt could not be opened");
            aborted = 1'b1;
        end

        while (!done && !aborted) begin
            if (steps >= MAX_STEPS) begin
                $display("Trace longer than %0d steps, run stopped", MAX_STEPS);
                aborted = 1'b1;
            end else begin
                steps++;
                ch = $fgetc(fd);
                if (ch < 0) begin
                    done = 1'b1;
                end else if (ch == "#") begin
                    n_read = $fgets(skip_buf, fd);
                end else if (ch > 32) begin
                    n_read = $fscanf(fd, " %h %h %h", t_addr, t_data, t_exp);
                    if (n_read != 3) begin
                        $display("Malformed trace entry for op '%c'", ch);
                        aborted = 1'b1;
                    end else begin
                        run_op(ch[7:0]);
                    end
                end
            end
        end

        if (fd != 0) begin
            $fclose(fd);
        end
        $display("checks run %0d, errors %0d", checks, errors);
        if (aborted || errors != 0) begin
            $display("CHECKS FAILED");
        end else begin
            $display("ALL CHECKS PASSED");
        end
        $finish;
    end

endmodule

/* verif/cr_io_trace.txt */
# op addr data expected, all hex; W write, R core read, B fabric read, I board inputs
# K scan strobe, E fpga_out pins, N idle cycles (count in data), T end of test (number in data)
R 00 0 0
R 04 0 0
R 08 0 0
R 0c 0 0
R 10 0 0
R 14 0 0
R 18 0 0
R 1c 0 0
R 20 0 0
R 24 0 0
R 28 0 0
R 2c 0 0
R 30 0 0
R 34 0 0
R 38 0 0
E 0 0 0
T 0 1 0
W 00 1a5 0
W 04 13c 0
W 08 212 0
W 0c ff77 0
W 10 80 0
W 14 1ff 0
W 18 fffffd2b 0
N 0 1 0
E 0 0 294f049de03fd2b
R 00 0 a5
R 18 0 12b
T 0 2 0
I 0 aa5abc123 0
N 0 1 0
R 20 0 1
R 24 0 0
R 28 0 2a5
R 2c 0 abc
R 30 0 123
W 28 fff 0
R 28 0 2a5
E 0 0 294f049de03fd2b
T 0 3 0
B 28 0 2a5
B 18 0 12b
R 3c 0 0
B 3c 0 0
B 1000 0 0
T 0 4 0
K 0 11 0
R 34 0 0
W 1c 1 0
K 0 21 0
K 0 22 0
K 0 23 0
K 0 24 0
K 0 25 0
N 0 1 0
R 34 0 1
R 38 0 21
N 0 1 0
R 38 0 22
N 0 1 0
R 38 0 23
N 0 1 0
R 38 0 24
N 0 1 0
R 34 0 0
T 0 5 0
